// File: project.f
source/miner_ocl_pkg.sv
source/ocl_write_channel.sv
source/miner_ctrl_regs.sv
source/ocl_read_channel.sv
source/vled_mask.sv
source/cl_miner_ocl.sv
test/tb_cl_miner_ocl.sv

// File: test/tb_cl_miner_ocl.sv
/*
  Directed testbench for the miner card register front end.
  Drives the AXI-Lite slave through single-beat writes and reads,
  watches the miner command pulses with a monitor and checks the
  register map, LED path, result reads and back-pressure.
  Prints one line per test and a closing summary.
*/

`timescale 1ns/10ps

module tb_cl_miner_ocl
  import miner_ocl_pkg::*;
;

  localparam int blk_cnt    = 8;
  localparam int wait_limit = 20;

  logic                       clk_main_a0;
  logic                       rst_main_n_sync;
  logic                       sh_ocl_awvalid;
  ocl_word_t                  sh_ocl_awaddr;
  logic                       ocl_sh_awready;
  logic                       sh_ocl_wvalid;
  ocl_word_t                  sh_ocl_wdata;
  logic                       ocl_sh_wready;
  logic                       ocl_sh_bvalid;
  logic [1:0]                 ocl_sh_bresp;
  logic                       sh_ocl_bready;
  logic                       sh_ocl_arvalid;
  ocl_word_t                  sh_ocl_araddr;
  logic                       ocl_sh_arready;
  logic                       ocl_sh_rvalid;
  ocl_word_t                  ocl_sh_rdata;
  logic [1:0]                 ocl_sh_rresp;
  logic                       sh_ocl_rready;
  logic [vled_w-1:0]          sh_cl_status_vdip;
  logic [vled_w-1:0]          cl_sh_status_vled;
  logic                       block_header_we;
  ocl_word_t                  block_header;
  logic                       matrix_fifo_we;
  ocl_word_t                  matrix_in;
  logic                       target_we;
  ocl_word_t                  target;
  ocl_word_t                  nonce_size;
  logic                       start;
  logic                       stop;
  logic [$clog2(blk_cnt)-1:0] hash_select;
  logic [miner_status_w-1:0]  status;
  ocl_word_t                  nonce;
  ocl_word_t                  heavyhash;
  logic                       hash_re;

  int        seed = 93413;
  int        err_cnt;
  int        check_cnt;
  int        test_cnt;
  ocl_word_t hello_word;

  // Monitor counters and captured pulse data
  int        bh_cnt;
  int        mx_cnt;
  int        tg_cnt;
  int        start_cnt;
  int        stop_cnt;
  int        stray_cnt;
  ocl_word_t bh_data;
  ocl_word_t mx_data;
  ocl_word_t tg_data;

  cl_miner_ocl #(
    .blk_cnt (blk_cnt)
  ) i_cl_miner_ocl (
    .*
  );

  // ------------------------------
  // Clock and miner side monitor
  // ------------------------------
  initial
  begin
    clk_main_a0 = 1'b0;
    forever
      #4 clk_main_a0 = ~clk_main_a0;
  end

  // Sampled mid cycle, where every pulse is stable
  always @(negedge clk_main_a0)
  begin
    if (rst_main_n_sync)
    begin
      if (block_header_we)
      begin
        bh_cnt++;
        bh_data = block_header;
      end
      if (matrix_fifo_we)
      begin
        mx_cnt++;
        mx_data = matrix_in;
      end
      if (target_we)
      begin
        tg_cnt++;
        tg_data = target;
      end
      if (start)
        start_cnt++;
      if (stop)
        stop_cnt++;
      // Data outside its we cycle must read zero
      if ((!block_header_we && block_header != '0) || (!matrix_fifo_we && matrix_in != '0) ||
          (!target_we && target != '0))
        stray_cnt++;
      // hash_re only together with a response
      if (hash_re && !ocl_sh_rvalid)
        stray_cnt++;
    end
  end

  // ------------------------------
  // Check and report helpers
  // ------------------------------
  task automatic check_word(input string what, input ocl_word_t got, input ocl_word_t exp);
    check_cnt++;
    assert (got === exp)
    else
    begin
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    check_cnt++;
    assert (got === exp)
    else
    begin
      $display("[ERROR] %0t ns: %s is %b, expected %b", $time, what, got, exp);
      err_cnt++;
    end
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout at %0t ns: %s", $time, what);
    $display("Test failures found");
    $finish;
  endtask

  task automatic finish_test(input string name, input int errs_before);
    test_cnt++;
    $display("%s finished with %0d errors", name, err_cnt - errs_before);
  endtask

  // Expected scratch read back, bytes reversed
  function automatic ocl_word_t byte_swap(input ocl_word_t w);
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
  endfunction

  // ------------------------------
  // AXI-Lite bus driver
  // ------------------------------
  // hold is the number of cycles bready stays low once bvalid is up
  task automatic axil_write(input ocl_word_t addr, input ocl_word_t data, input int hold);
    int cnt;
    @(posedge clk_main_a0);
    sh_ocl_awvalid <= 1'b1;
    sh_ocl_awaddr  <= addr;
    sh_ocl_wvalid  <= 1'b1;
    sh_ocl_wdata   <= data;
    sh_ocl_bready  <= (hold == 0);
    cnt = 0;
    @(negedge clk_main_a0);
    while (!ocl_sh_awready && cnt < wait_limit)
    begin
      @(negedge clk_main_a0);
      cnt++;
    end
    if (!ocl_sh_awready)
      stop_on_timeout("write address was never accepted");
    @(posedge clk_main_a0);
    sh_ocl_awvalid <= 1'b0;
    cnt = 0;
    @(negedge clk_main_a0);
    while (!ocl_sh_wready && cnt < wait_limit)
    begin
      @(negedge clk_main_a0);
      cnt++;
    end
    if (!ocl_sh_wready)
      stop_on_timeout("write data was never accepted");
    @(posedge clk_main_a0);
    sh_ocl_wvalid <= 1'b0;
    cnt = 0;
    @(negedge clk_main_a0);
    while (!ocl_sh_bvalid && cnt < wait_limit)
    begin
      @(negedge clk_main_a0);
      cnt++;
    end
    if (!ocl_sh_bvalid)
      stop_on_timeout("write response never arrived");
    check_word("bresp", ocl_word_t'(ocl_sh_bresp), '0);
    // Stalled response must hold and block new addresses
    repeat (hold)
    begin
      @(negedge clk_main_a0);
      check_bit("bvalid under stall", ocl_sh_bvalid, 1'b1);
      check_bit("awready under stall", ocl_sh_awready, 1'b0);
    end
    if (hold > 0)
    begin
      @(posedge clk_main_a0);
      sh_ocl_bready <= 1'b1;
      @(negedge clk_main_a0);
      check_bit("bvalid at release", ocl_sh_bvalid, 1'b1);
    end
    @(posedge clk_main_a0);
  endtask

  // hold is the number of cycles rready stays low once rvalid is up
  task automatic axil_read(input ocl_word_t addr, input int hold, output ocl_word_t data,
                           output logic hre);
    int cnt;
    @(posedge clk_main_a0);
    sh_ocl_arvalid <= 1'b1;
    sh_ocl_araddr  <= addr;
    sh_ocl_rready  <= (hold == 0);
    cnt = 0;
    @(negedge clk_main_a0);
    while (!ocl_sh_arready && cnt < wait_limit)
    begin
      @(negedge clk_main_a0);
      cnt++;
    end
    if (!ocl_sh_arready)
      stop_on_timeout("read address was never accepted");
    @(posedge clk_main_a0);
    sh_ocl_arvalid <= 1'b0;
    cnt = 0;
    @(negedge clk_main_a0);
    while (!ocl_sh_rvalid && cnt < wait_limit)
    begin
      @(negedge clk_main_a0);
      cnt++;
    end
    if (!ocl_sh_rvalid)
      stop_on_timeout("read response never arrived");
    data = ocl_sh_rdata;
    hre  = hash_re;
    check_word("rresp", ocl_word_t'(ocl_sh_rresp), '0);
    repeat (hold)
    begin
      @(negedge clk_main_a0);
      check_bit("rvalid under stall", ocl_sh_rvalid, 1'b1);
      check_word("rdata under stall", ocl_sh_rdata, data);
      check_bit("arready under stall", ocl_sh_arready, 1'b0);
    end
    if (hold > 0)
    begin
      @(posedge clk_main_a0);
      sh_ocl_rready <= 1'b1;
      @(negedge clk_main_a0);
      check_bit("rvalid at release", ocl_sh_rvalid, 1'b1);
    end
    @(posedge clk_main_a0);
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  task automatic reset_values();
    int e0;
    e0 = err_cnt;
    @(negedge clk_main_a0);
    check_bit("awready after reset", ocl_sh_awready, 1'b1);
    check_bit("arready after reset", ocl_sh_arready, 1'b1);
    check_bit("bvalid after reset", ocl_sh_bvalid, 1'b0);
    check_bit("rvalid after reset", ocl_sh_rvalid, 1'b0);
    check_bit("hash_re after reset", hash_re, 1'b0);
    check_word("nonce_size after reset", nonce_size, '0);
    check_word("hash_select after reset", ocl_word_t'(hash_select), '0);
    check_word("vled after reset", ocl_word_t'(cl_sh_status_vled), '0);
    finish_test("Reset values", e0);
  endtask

  task automatic scratch_readback();
    int        e0;
    ocl_word_t rd;
    logic      hre;
    e0 = err_cnt;
    hello_word = $random(seed);
    axil_write(ocl_addr_hello_world, hello_word, 0);
    axil_read(ocl_addr_hello_world, 0, rd, hre);
    check_word("scratch read back", rd, byte_swap(hello_word));
    finish_test("Scratch register", e0);
  endtask

  task automatic vled_follow();
    int                e0;
    int                cnt;
    logic [vled_w-1:0] vdip;
    logic [vled_w-1:0] exp_led;
    ocl_word_t         rd;
    logic              hre;
    e0      = err_cnt;
    vdip    = $random(seed);
    exp_led = hello_word[vled_w-1:0] & vdip;
    @(posedge clk_main_a0);
    sh_cl_status_vdip <= vdip;
    cnt = 0;
    // LED must settle within three cycles
    @(negedge clk_main_a0);
    while (cl_sh_status_vled !== exp_led && cnt < 3)
    begin
      @(negedge clk_main_a0);
      cnt++;
    end
    check_word("masked LED output", ocl_word_t'(cl_sh_status_vled), ocl_word_t'(exp_led));
    // Register read is the unmasked shadow
    axil_read(ocl_addr_vled, 0, rd, hre);
    check_word("vled read", rd, {16'h0000, hello_word[15:0]});
    finish_test("Virtual LED", e0);
  endtask

  task automatic miner_commands();
    int        e0;
    int        n0;
    ocl_word_t d;
    e0 = err_cnt;
    n0 = bh_cnt;
    d  = $random(seed);
    axil_write(ocl_addr_block_header, d, 0);
    check_word("block header pulses", bh_cnt - n0, 1);
    check_word("block header data", bh_data, d);
    n0 = mx_cnt;
    d  = $random(seed);
    axil_write(ocl_addr_matrix, d, 0);
    check_word("matrix pulses", mx_cnt - n0, 1);
    check_word("matrix data", mx_data, d);
    n0 = tg_cnt;
    d  = $random(seed);
    axil_write(ocl_addr_target, d, 0);
    check_word("target pulses", tg_cnt - n0, 1);
    check_word("target data", tg_data, d);
    n0 = start_cnt;
    axil_write(ocl_addr_start, 32'h1, 0);
    check_word("start pulses", start_cnt - n0, 1);
    n0 = stop_cnt;
    axil_write(ocl_addr_stop, 32'h1, 0);
    check_word("stop pulses", stop_cnt - n0, 1);
    d = $random(seed);
    axil_write(ocl_addr_nonce_size, d, 0);
    @(negedge clk_main_a0);
    check_word("nonce_size", nonce_size, d);
    axil_write(ocl_addr_hash_select, 32'hFFFF_FFFF, 0);
    @(negedge clk_main_a0);
    check_word("hash_select", ocl_word_t'(hash_select), ocl_word_t'(blk_cnt - 1));
    check_word("stray miner outputs", stray_cnt, 0);
    finish_test("Miner commands", e0);
  endtask

  task automatic miner_results();
    int                        e0;
    logic [miner_status_w-1:0] st;
    ocl_word_t                 nc;
    ocl_word_t                 hh;
    ocl_word_t                 rd;
    logic                      hre;
    e0 = err_cnt;
    st = $random(seed);
    nc = $random(seed);
    hh = $random(seed);
    @(posedge clk_main_a0);
    status    <= st;
    nonce     <= nc;
    heavyhash <= hh;
    axil_read(ocl_addr_status, 0, rd, hre);
    check_word("status read", rd, {30'h0, st});
    check_bit("hash_re on status read", hre, 1'b0);
    axil_read(ocl_addr_nonce, 0, rd, hre);
    check_word("nonce read", rd, nc);
    check_bit("hash_re on nonce read", hre, 1'b0);
    axil_read(ocl_addr_heavyhash, 0, rd, hre);
    check_word("heavy hash read", rd, hh);
    check_bit("hash_re on heavy hash read", hre, 1'b1);
    @(negedge clk_main_a0);
    check_bit("hash_re after heavy hash read", hash_re, 1'b0);
    check_word("stray hash_re", stray_cnt, 0);
    finish_test("Miner results", e0);
  endtask

  task automatic unmapped_read();
    int        e0;
    ocl_word_t rd;
    logic      hre;
    e0 = err_cnt;
    axil_read(32'h0000_0600, 0, rd, hre);
    check_word("unmapped read", rd, 32'hDEAD_BEEF);
    finish_test("Unimplemented address", e0);
  endtask

  task automatic back_pressure();
    int        e0;
    ocl_word_t d;
    ocl_word_t rd;
    logic      hre;
    e0 = err_cnt;
    d  = $random(seed);
    axil_write(ocl_addr_nonce_size, d, 10);
    @(negedge clk_main_a0);
    check_word("nonce_size after stalled write", nonce_size, d);
    // Write side idle again after the B handshake
    check_bit("bvalid after release", ocl_sh_bvalid, 1'b0);
    check_bit("awready after release", ocl_sh_awready, 1'b1);
    axil_read(ocl_addr_hello_world, 10, rd, hre);
    @(negedge clk_main_a0);
    // Read side idle again after the R handshake
    check_bit("rvalid after release", ocl_sh_rvalid, 1'b0);
    check_bit("arready after release", ocl_sh_arready, 1'b1);
    check_word("stalled scratch read", rd, byte_swap(hello_word));
    finish_test("Back-pressure", e0);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial
  begin
    rst_main_n_sync   = 1'b0;
    sh_ocl_awvalid    = 1'b0;
    sh_ocl_awaddr     = '0;
    sh_ocl_wvalid     = 1'b0;
    sh_ocl_wdata      = '0;
    sh_ocl_bready     = 1'b1;
    sh_ocl_arvalid    = 1'b0;
    sh_ocl_araddr     = '0;
    sh_ocl_rready     = 1'b1;
    sh_cl_status_vdip = '0;
    status            = '0;
    nonce             = '0;
    heavyhash         = '0;
    repeat (8)
      @(posedge clk_main_a0);
    rst_main_n_sync <= 1'b1;
    reset_values();
    scratch_readback();
    vled_follow();
    miner_commands();
    miner_results();
    unmapped_read();
    back_pressure();
    $display("Tests run: %0d, checks: %0d, errors: %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

endmodule

// File: source/cl_miner_ocl.sv
/*
  Top level of the miner card register front end.
  Connects the AXI-Lite write and read channels, the write decode
  stage and the LED path to plain host, shell and miner ports.
  blk_cnt is passed down to size the hash select field.
*/

`timescale 1ns/10ps

module cl_miner_ocl
  import miner_ocl_pkg::*;
#(
  parameter int blk_cnt = 8
)
(
  input  logic                       clk_main_a0,
  input  logic                       rst_main_n_sync,

  // AXI-Lite slave
  input  logic                       sh_ocl_awvalid,
  input  ocl_word_t                  sh_ocl_awaddr,
  output logic                       ocl_sh_awready,
  input  logic                       sh_ocl_wvalid,
  input  ocl_word_t                  sh_ocl_wdata,
  output logic                       ocl_sh_wready,
  output logic                       ocl_sh_bvalid,
  output logic [1:0]                 ocl_sh_bresp,
  input  logic                       sh_ocl_bready,
  input  logic                       sh_ocl_arvalid,
  input  ocl_word_t                  sh_ocl_araddr,
  output logic                       ocl_sh_arready,
  output logic                       ocl_sh_rvalid,
  output ocl_word_t                  ocl_sh_rdata,
  output logic [1:0]                 ocl_sh_rresp,
  input  logic                       sh_ocl_rready,

  // Shell status
  input  logic [vled_w-1:0]          sh_cl_status_vdip,
  output logic [vled_w-1:0]          cl_sh_status_vled,

  // Miner commands
  output logic                       block_header_we,
  output ocl_word_t                  block_header,
  output logic                       matrix_fifo_we,
  output ocl_word_t                  matrix_in,
  output logic                       target_we,
  output ocl_word_t                  target,
  output ocl_word_t                  nonce_size,
  output logic                       start,
  output logic                       stop,
  output logic [$clog2(blk_cnt)-1:0] hash_select,

  // Miner results
  input  logic [miner_status_w-1:0]  status,
  input  ocl_word_t                  nonce,
  input  ocl_word_t                  heavyhash,
  output logic                       hash_re
);

  logic              wr_strobe;
  ocl_word_t         wr_addr;
  ocl_word_t         hello_value;
  ocl_word_t         hello_swapped;
  logic [vled_w-1:0] vled_value;

  // ------------------------------
  // Write pipeline
  // ------------------------------
  ocl_write_channel i_ocl_write_channel (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (sh_ocl_awvalid),
    .awaddr          (sh_ocl_awaddr),
    .awready         (ocl_sh_awready),
    .wvalid          (sh_ocl_wvalid),
    .wready          (ocl_sh_wready),
    .bvalid          (ocl_sh_bvalid),
    .bresp           (ocl_sh_bresp),
    .bready          (sh_ocl_bready),
    .wr_strobe       (wr_strobe),
    .wr_addr         (wr_addr)
  );

  // Write data taken straight from the bus in the strobe cycle
  miner_ctrl_regs #(
    .blk_cnt (blk_cnt)
  ) i_miner_ctrl_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .wr_strobe       (wr_strobe),
    .wr_addr         (wr_addr),
    .wr_data         (sh_ocl_wdata),
    .hello_value     (hello_value),
    .hello_swapped   (hello_swapped),
    .block_header_we (block_header_we),
    .block_header    (block_header),
    .matrix_fifo_we  (matrix_fifo_we),
    .matrix_in       (matrix_in),
    .target_we       (target_we),
    .target          (target),
    .nonce_size      (nonce_size),
    .start           (start),
    .stop            (stop),
    .hash_select     (hash_select)
  );

  // ------------------------------
  // Read pipeline
  // ------------------------------
  ocl_read_channel i_ocl_read_channel (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .arvalid         (sh_ocl_arvalid),
    .araddr          (sh_ocl_araddr),
    .arready         (ocl_sh_arready),
    .rvalid          (ocl_sh_rvalid),
    .rdata           (ocl_sh_rdata),
    .rresp           (ocl_sh_rresp),
    .rready          (sh_ocl_rready),
    .hello_swapped   (hello_swapped),
    .vled_value      (vled_value),
    .status          (status),
    .nonce           (nonce),
    .heavyhash       (heavyhash),
    .hash_re         (hash_re)
  );

  // LED shadow beside the pipelines
  vled_mask i_vled_mask (
    .clk_main_a0       (clk_main_a0),
    .rst_main_n_sync   (rst_main_n_sync),
    .hello_value       (hello_value),
    .sh_cl_status_vdip (sh_cl_status_vdip),
    .vled_value        (vled_value),
    .cl_sh_status_vled (cl_sh_status_vled)
  );

endmodule

// File: source/vled_mask.sv
/*
  Virtual LED path.
  Shadows the low half of the scratch register as the LED value
  and drives the shell LED output masked by the virtual DIP
  switches after a two-flop synchronizer.
*/

`timescale 1ns/10ps

module vled_mask
  import miner_ocl_pkg::*;
(
  input  logic              clk_main_a0,
  input  logic              rst_main_n_sync,
  input  ocl_word_t         hello_value,
  input  logic [vled_w-1:0] sh_cl_status_vdip,
  output logic [vled_w-1:0] vled_value,
  output logic [vled_w-1:0] cl_sh_status_vled
);

  logic [vled_w-1:0] vdip_q1;
  logic [vled_w-1:0] vdip_q2;

  // ------------------------------
  // Shadow, sync and mask
  // ------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      vled_value        <= '0;
      vdip_q1           <= '0;
      vdip_q2           <= '0;
      cl_sh_status_vled <= '0;
    end
    else
    begin
      // Low half of scratch only
      vled_value        <= hello_value[vled_w-1:0];
      vdip_q1           <= sh_cl_status_vdip;
      vdip_q2           <= vdip_q1;
      cl_sh_status_vled <= vled_value & vdip_q2;
    end
  end

endmodule

// File: source/ocl_read_channel.sv
/*
  AXI-Lite read side of the register front end.
  Registers the accepted read request, then loads the response
  word from the scratch, LED and miner result sources.
  Response is held until rready. hash_re tells the miner that
  its heavy hash word is being read.
*/

`timescale 1ns/10ps

module ocl_read_channel
  import miner_ocl_pkg::*;
(
  input  logic                      clk_main_a0,
  input  logic                      rst_main_n_sync,
  input  logic                      arvalid,
  input  ocl_word_t                 araddr,
  output logic                      arready,
  output logic                      rvalid,
  output ocl_word_t                 rdata,
  output logic [1:0]                rresp,
  input  logic                      rready,
  input  ocl_word_t                 hello_swapped,
  input  logic [vled_w-1:0]         vled_value,
  input  logic [miner_status_w-1:0] status,
  input  ocl_word_t                 nonce,
  input  ocl_word_t                 heavyhash,
  output logic                      hash_re
);

  logic      arvalid_q;
  ocl_word_t araddr_q;
  ocl_word_t read_word;
  logic      ar_accept;

  // Busy from request capture through the R handshake
  assign arready   = ~arvalid_q & ~rvalid;
  assign ar_accept = arvalid & arready;

  assign rresp = 2'b00;

  // ------------------------------
  // Request stage
  // ------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
      arvalid_q <= 1'b0;
    else
      arvalid_q <= ar_accept;
  end

  always_ff @(posedge clk_main_a0)
  begin
    if (ar_accept)
      araddr_q <= araddr;
  end

  // ------------------------------
  // Read data select
  // ------------------------------
  always_comb
  begin
    case (araddr_q)
      ocl_addr_hello_world: read_word = hello_swapped;
      ocl_addr_vled:        read_word = {{(ocl_data_w-vled_w){1'b0}}, vled_value};
      ocl_addr_status:      read_word = {{(ocl_data_w-miner_status_w){1'b0}}, status};
      ocl_addr_nonce:       read_word = nonce;
      ocl_addr_heavyhash:   read_word = heavyhash;
      default:              read_word = ocl_unimplemented_value;
    endcase
  end

  // ------------------------------
  // Response stage
  // ------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      rvalid  <= 1'b0;
      hash_re <= 1'b0;
    end
    else if (rvalid)
    begin
      rvalid  <= ~rready;
      hash_re <= hash_re & ~rready;
    end
    else
    begin
      rvalid  <= arvalid_q;
      hash_re <= arvalid_q && (araddr_q == ocl_addr_heavyhash);
    end
  end

  // Loaded once per request, frozen while the host stalls
  always_ff @(posedge clk_main_a0)
  begin
    if (arvalid_q)
      rdata <= read_word;
  end

  // Stalled response keeps its word
  a_rdata_stable: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

// File: source/miner_ctrl_regs.sv
/*
  Write decode stage of the register front end.
  Takes the write strobe, address and data from the write channel,
  keeps the scratch register, and drives the miner command pulses
  and held levels one cycle after the strobe.
  blk_cnt sets the width of the hash select field.
*/

`timescale 1ns/10ps

module miner_ctrl_regs
  import miner_ocl_pkg::*;
#(
  parameter int blk_cnt = 8
)
(
  input  logic                       clk_main_a0,
  input  logic                       rst_main_n_sync,
  input  logic                       wr_strobe,
  input  ocl_word_t                  wr_addr,
  input  ocl_word_t                  wr_data,
  output ocl_word_t                  hello_value,
  output ocl_word_t                  hello_swapped,
  output logic                       block_header_we,
  output ocl_word_t                  block_header,
  output logic                       matrix_fifo_we,
  output ocl_word_t                  matrix_in,
  output logic                       target_we,
  output ocl_word_t                  target,
  output ocl_word_t                  nonce_size,
  output logic                       start,
  output logic                       stop,
  output logic [$clog2(blk_cnt)-1:0] hash_select
);

  localparam int sel_w = $clog2(blk_cnt);

  ocl_word_view_t hello_q;
  ocl_word_view_t hello_sw;

  logic hit_hello;
  logic hit_block_header;
  logic hit_matrix;
  logic hit_target;
  logic hit_nonce_size;
  logic hit_start;
  logic hit_stop;
  logic hit_hash_select;

  // ------------------------------
  // Address decode
  // ------------------------------
  assign hit_hello        = wr_strobe && (wr_addr == ocl_addr_hello_world);
  assign hit_block_header = wr_strobe && (wr_addr == ocl_addr_block_header);
  assign hit_matrix       = wr_strobe && (wr_addr == ocl_addr_matrix);
  assign hit_target       = wr_strobe && (wr_addr == ocl_addr_target);
  assign hit_nonce_size   = wr_strobe && (wr_addr == ocl_addr_nonce_size);
  assign hit_start        = wr_strobe && (wr_addr == ocl_addr_start);
  assign hit_stop         = wr_strobe && (wr_addr == ocl_addr_stop);
  assign hit_hash_select  = wr_strobe && (wr_addr == ocl_addr_hash_select);

  // ------------------------------
  // Scratch register
  // ------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
      hello_q.word <= '0;
    else if (hit_hello)
      hello_q.word <= wr_data;
  end

  // Byte order reversed for read back
  always_comb
  begin
    for (int i = 0; i < 4; i++)
      hello_sw.bytes[i] = hello_q.bytes[3-i];
  end

  assign hello_value   = hello_q.word;
  assign hello_swapped = hello_sw.word;

  // ------------------------------
  // Miner commands
  // ------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      block_header_we <= 1'b0;
      matrix_fifo_we  <= 1'b0;
      target_we       <= 1'b0;
      block_header    <= '0;
      matrix_in       <= '0;
      target          <= '0;
      start           <= 1'b0;
      stop            <= 1'b0;
      nonce_size      <= '0;
      hash_select     <= '0;
    end
    else
    begin
      // One cycle pulses, data only present with its we
      block_header_we <= hit_block_header;
      matrix_fifo_we  <= hit_matrix;
      target_we       <= hit_target;
      block_header    <= hit_block_header ? wr_data : '0;
      matrix_in       <= hit_matrix ? wr_data : '0;
      target          <= hit_target ? wr_data : '0;
      start           <= hit_start;
      stop            <= hit_stop;
      // Held levels
      if (hit_nonce_size)
        nonce_size <= wr_data;
      if (hit_hash_select)
        hash_select <= wr_data[sel_w-1:0];
    end
  end

  // Miner never sees two commands in the same cycle
  a_cmd_onehot: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    $onehot0({block_header_we, matrix_fifo_we, target_we, start, stop}));

endmodule

// File: source/ocl_write_channel.sv
/*
  AXI-Lite write side of the register front end.
  Accepts one address, waits for its data beat, and turns the
  data handshake into a single-cycle write strobe for the decode
  stage. The response is held until the host takes it.
*/

`timescale 1ns/10ps

module ocl_write_channel
  import miner_ocl_pkg::*;
(
  input  logic      clk_main_a0,
  input  logic      rst_main_n_sync,
  input  logic      awvalid,
  input  ocl_word_t awaddr,
  output logic      awready,
  input  logic      wvalid,
  output logic      wready,
  output logic      bvalid,
  output logic [1:0] bresp,
  input  logic      bready,
  output logic      wr_strobe,
  output ocl_word_t wr_addr
);

  logic wr_active;

  // Idle means a new address can be taken
  assign awready = ~wr_active;

  // Data beat only before the response is out
  assign wready    = wr_active & ~bvalid & wvalid;
  assign wr_strobe = wready;

  // Always OKAY
  assign bresp = 2'b00;

  // ------------------------------
  // Write active flag and response
  // ------------------------------
  always_ff @(posedge clk_main_a0)
  begin
    if (!rst_main_n_sync)
    begin
      wr_active <= 1'b0;
      bvalid    <= 1'b0;
    end
    else
    begin
      // Cleared by the B handshake only
      if (wr_active)
        wr_active <= ~(bvalid & bready);
      else
        wr_active <= awvalid;
      if (bvalid)
        bvalid <= ~bready;
      else
        bvalid <= wr_strobe;
    end
  end

  // Address capture on AW handshake
  always_ff @(posedge clk_main_a0)
  begin
    if (awvalid && awready)
      wr_addr <= awaddr;
  end

  // Response never withdrawn before the host accepts it
  a_bvalid_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    bvalid && !bready |=> bvalid);

endmodule

// File: source/miner_ocl_pkg.sv
/*
  Shared definitions for the miner card register front end.
  Holds the AXI-Lite word type, the register map, the value
  returned for unmapped reads and the LED and status widths.
  Modules pull these in with a wildcard import in their header.
*/

package miner_ocl_pkg;

  // ------------------------------
  // Bus word
  // ------------------------------
  localparam int ocl_data_w = 32;

  typedef logic [ocl_data_w-1:0] ocl_word_t;

  // Same word seen whole or as four bytes
  typedef union packed {
    ocl_word_t       word;
    logic [3:0][7:0] bytes;
  } ocl_word_view_t;

  // ------------------------------
  // Register map
  // ------------------------------
  localparam ocl_word_t ocl_addr_hello_world  = 32'h0000_0500;
  localparam ocl_word_t ocl_addr_vled         = 32'h0000_0504;
  localparam ocl_word_t ocl_addr_status       = 32'h0000_0508;
  localparam ocl_word_t ocl_addr_nonce        = 32'h0000_050C;
  localparam ocl_word_t ocl_addr_heavyhash    = 32'h0000_0510;
  localparam ocl_word_t ocl_addr_block_header = 32'h0000_0514;
  localparam ocl_word_t ocl_addr_matrix       = 32'h0000_0518;
  localparam ocl_word_t ocl_addr_target       = 32'h0000_051C;
  localparam ocl_word_t ocl_addr_nonce_size   = 32'h0000_0520;
  localparam ocl_word_t ocl_addr_start        = 32'h0000_0524;
  localparam ocl_word_t ocl_addr_stop         = 32'h0000_0528;
  localparam ocl_word_t ocl_addr_hash_select  = 32'h0000_052C;

  // Returned for any address outside the map
  localparam ocl_word_t ocl_unimplemented_value = 32'hDEAD_BEEF;

  // ------------------------------
  // Side band widths
  // ------------------------------
  localparam int vled_w         = 16;
  localparam int miner_status_w = 2;

endpackage
